// File: dv/exec_golden.txt
# mode name opcode a b result status, all hex but mode and name
# mode 0 full run, 1 issue only, 2 command only then check
0 add_basic      0 00000005 00000007 0000000c 1
0 add_ovf        0 7fffffff 00000001 80000000 3
0 sub_basic      1 00000010 00000003 0000000d 1
0 sub_underflow  1 80000000 00000001 7fffffff 3
0 and_mix        2 f0f0ff00 ff00f0f0 f000f000 1
0 or_mix         3 f0f0ff00 ff00f0f0 fff0fff0 1
0 xor_mix        4 f0f0ff00 ff00f0f0 0ff00ff0 1
0 nor_mix        5 f0f0ff00 ff00f0f0 000f000f 1
0 slt_mixed      6 ffffffff 00000001 00000001 1
0 sltu_mixed     7 ffffffff 00000001 00000000 1
0 lui_upper      8 00000000 abcd1234 12340000 1
0 sll_0          9 87654321 00000000 87654321 1
0 sll_1          9 87654321 00000001 0eca8642 1
0 sll_17_hi_b    9 87654321 fffffff1 86420000 1
0 srl_16         a 87654321 00000010 00008765 1
0 srl_31         a 87654321 0000001f 00000001 1
0 sra_1          b 87654321 00000001 c3b2a190 1
0 sra_17         b 87654321 00000011 ffffc3b2 1
0 sra_31         b 87654321 0000001f ffffffff 1
0 illegal_op     c 12345678 9abcdef0 00000000 5
1 b2b_first      0 00000001 00000002 00000003 1
2 b2b_second     1 00000001 00000002 ffffffff 1

// File: filelist.f
design/alu_pkg.sv
design/bus_pkg.sv
design/shifter.sv
design/alu.sv
design/exec_pipe.sv
design/wb_regs.sv
design/exec_top.sv
dv/tb_exec_top.sv

// File: run_sim.sh
#!/bin/sh
# build with verilator, run, then judge the run from the log
rm -f sim.log
verilator --binary --top-module tb_exec_top -f filelist.f -o tb_exec_top > build.log 2>&1 \
	|| { cat build.log; exit 1; }
./obj_dir/tb_exec_top > sim.log 2>&1
cat sim.log
grep -qF '*** TEST FAILED ***' sim.log && exit 1
grep -qF '*** TEST PASSED ***' sim.log || exit 1
exit 0

// File: dv/tb_exec_top.sv
/* testbench for exec_top, replays the golden file over the wishbone port
   and compares result and status words */
module tb_exec_top;
	import bus_pkg::*;

	localparam int ack_timeout  = 20; // cycles per bus access
	localparam int busy_timeout = 10; // cycles of status polling

	logic    clock;
	logic    rst_n;
	wb_req_t wb_req;
	wb_rsp_t wb_rsp;

	int              cycle_cnt = 0;
	int              fd;
	int              nchar;
	int              nfields;
	int              n_tests;
	int              mode;
	string           line;
	logic [8*24-1:0] name;
	logic [3:0]      op;
	logic [31:0]     opa;
	logic [31:0]     opb;
	logic [31:0]     exp_result;
	logic [31:0]     exp_status;
	logic [31:0]     rdata;

	exec_top i_dut (
		.clock  (clock),
		.rst_n  (rst_n),
		.wb_req (wb_req),
		.wb_rsp (wb_rsp)
	);

	always #10 clock = ~clock;

	always @(posedge clock) cycle_cnt <= cycle_cnt + 1;

	task automatic fail_run;
		$display("*** TEST FAILED ***");
		$fatal(1);
	endtask

	task automatic check(input string test, input logic [31:0] expected,
			input logic [31:0] actual);
		if (expected !== actual) begin
			$display("mismatch %0s: expected %08h, actual %08h", test, expected, actual);
			fail_run();
		end
	endtask

	// ack is sampled 2 units after the edge, where it is stable
	task automatic wait_ack(input logic [4:0] adr);
		int cycles;
		cycles = 0;
		while (!wb_rsp.ack) begin
			if (cycles == ack_timeout) begin
				$display("no bus acknowledge for address %02h after %0d cycles", adr, cycles);
				fail_run();
			end
			@(posedge clock);
			#2;
			cycles++;
		end
	endtask

	task automatic wb_write(input logic [4:0] adr, input logic [31:0] dat);
		@(posedge clock);
		#2;
		wb_req.cyc = 1'b1;
		wb_req.stb = 1'b1;
		wb_req.we  = 1'b1;
		wb_req.adr = adr;
		wb_req.dat = dat;
		wait_ack(adr);
		@(posedge clock); // slave takes the write on this edge
		#2;
		wb_req = '0;
	endtask

	task automatic wb_read(input logic [4:0] adr, output logic [31:0] dat);
		@(posedge clock);
		#2;
		wb_req.cyc = 1'b1;
		wb_req.stb = 1'b1;
		wb_req.we  = 1'b0;
		wb_req.adr = adr;
		wb_req.dat = '0;
		wait_ack(adr);
		dat = wb_rsp.dat;
		@(posedge clock);
		#2;
		wb_req = '0;
	endtask

	task automatic wait_idle(input string test, output logic [31:0] status);
		int          start;
		logic [31:0] st;
		start = cycle_cnt;
		wb_read(adr_status, st);
		// first poll lands two cycles after the command ack, result still in flight
		check({test, " busy"}, 32'h1, {31'h0, st[st_busy]});
		while (st[st_busy]) begin
			if (cycle_cnt - start > busy_timeout) begin
				$display("status busy still set after %0d cycles", cycle_cnt - start);
				fail_run();
			end
			wb_read(adr_status, st);
		end
		status = st;
	endtask

	// mode 1 issues without polling, mode 2 reuses the operands already written
	task automatic run_line;
		string       tn;
		logic [31:0] status;
		tn = $sformatf("%0s", name);
		if (mode != 2) begin
			wb_write(adr_opa, opa);
			wb_write(adr_opb, opb);
		end
		wb_write(adr_cmd, {28'h0, op});
		if (mode != 1) begin
			wait_idle(tn, status);
			check({tn, " status"}, exp_status, status);
			wb_read(adr_result, rdata);
			check({tn, " result"}, exp_result, rdata);
			wb_read(adr_status, status); // result read clears done
			check({tn, " done clear"}, exp_status & ~(32'h1 << st_done), status);
		end
	endtask

	initial begin
		clock   = 1'b0;
		rst_n   = 1'b0;
		wb_req  = '0;
		n_tests = 0;
		repeat (4) @(posedge clock);
		#2;
		rst_n = 1'b1;

		wb_read(adr_status, rdata);
		check("reset status", 32'h0, rdata);
		wb_read(adr_result, rdata);
		check("reset result", 32'h0, rdata);

		fd = $fopen("dv/exec_golden.txt", "r");
		if (fd == 0) begin
			$display("cannot open dv/exec_golden.txt");
			fail_run();
		end
		while (!$feof(fd)) begin
			nchar = $fgets(line, fd);
			if (nchar > 1 && line.getc(0) != "#") begin
				nfields = $sscanf(line, "%d %s %h %h %h %h %h", mode, name, op, opa, opb,
					exp_result, exp_status);
				if (nfields != 7) begin
					$display("malformed golden line: %0s", line);
					fail_run();
				end
				run_line();
				n_tests++;
			end
		end
		$fclose(fd);

		if (n_tests == 0) begin
			$display("golden file holds no operations");
			fail_run();
		end else begin
			$display("*** TEST PASSED ***");
			$finish;
		end
	end

endmodule

// File: design/exec_top.sv
/* execute coprocessor top, bus slave plus pipeline */
module exec_top (
	input  logic             clock,
	input  logic             rst_n,
	input  bus_pkg::wb_req_t wb_req,
	output bus_pkg::wb_rsp_t wb_rsp
);
	import alu_pkg::*;

	logic      issue_valid;
	exec_req_t req;
	logic      busy;
	logic      rsp_valid;
	exec_rsp_t rsp;

	wb_regs i_wb_regs (
		.clock       (clock),
		.rst_n       (rst_n),
		.wb_req      (wb_req),
		.wb_rsp      (wb_rsp),
		.issue_valid (issue_valid),
		.req         (req),
		.busy        (busy),
		.rsp_valid   (rsp_valid),
		.rsp         (rsp)
	);

	exec_pipe i_exec_pipe (
		.clock       (clock),
		.rst_n       (rst_n),
		.issue_valid (issue_valid),
		.req         (req),
		.busy        (busy),
		.rsp_valid   (rsp_valid),
		.rsp         (rsp)
	);

endmodule

// File: design/wb_regs.sv
/* wishbone classic slave holding operands, command, result and status,
   launches a command to the execute pipeline on a command write */
module wb_regs (
	input  logic               clock,
	input  logic               rst_n,
	input  bus_pkg::wb_req_t   wb_req,
	output bus_pkg::wb_rsp_t   wb_rsp,
	output logic               issue_valid,
	output alu_pkg::exec_req_t req,
	input  logic               busy,
	input  logic               rsp_valid,
	input  alu_pkg::exec_rsp_t rsp
);
	import alu_pkg::*;
	import bus_pkg::*;

	typedef enum logic {
		st_idle,
		st_ack
	} ack_state_e;

	ack_state_e        state;
	logic              stb_q;
	logic              start;
	logic              wr_en;
	logic              sel_opa;
	logic              sel_opb;
	logic              sel_cmd;
	logic              sel_result;
	logic              sel_status;

	logic [data_w-1:0] opa_q;
	logic [data_w-1:0] opb_q;
	logic [3:0]        cmd_q;
	logic [data_w-1:0] result_q;
	logic              done_q;
	logic              ovf_q;
	logic              illegal_q;
	logic [wb_dw-1:0]  status;
	logic [wb_dw-1:0]  rd_mux;
	logic [wb_dw-1:0]  rd_q;

	// new access only after stb has been low for a cycle
	assign start = (state == st_idle) && wb_req.cyc && wb_req.stb && !stb_q;
	assign wr_en = (state == st_ack) && wb_req.we;

	assign sel_opa    = (wb_req.adr == adr_opa);
	assign sel_opb    = (wb_req.adr == adr_opb);
	assign sel_cmd    = (wb_req.adr == adr_cmd);
	assign sel_result = (wb_req.adr == adr_result);
	assign sel_status = (wb_req.adr == adr_status);

	always_ff @(posedge clock or negedge rst_n) begin
		if (!rst_n) begin
			state <= st_idle;
			stb_q <= 1'b0;
		end else begin
			stb_q <= wb_req.cyc && wb_req.stb;
			state <= start ? st_ack : st_idle; // ack lasts one cycle
		end
	end

	always_ff @(posedge clock or negedge rst_n) begin
		if (!rst_n) begin
			opa_q <= '0;
			opb_q <= '0;
			cmd_q <= '0;
		end else if (wr_en) begin
			if (sel_opa) opa_q <= wb_req.dat;
			if (sel_opb) opb_q <= wb_req.dat;
			if (sel_cmd) cmd_q <= wb_req.dat[3:0];
		end
	end

	assign issue_valid = wr_en && sel_cmd;
	assign req.op = op_e'(wb_req.dat[3:0]);
	assign req.a  = opa_q;
	assign req.b  = opb_q;

	always_ff @(posedge clock or negedge rst_n) begin
		if (!rst_n) begin
			result_q  <= '0;
			done_q    <= 1'b0;
			ovf_q     <= 1'b0;
			illegal_q <= 1'b0;
		end else begin
			if (start && !wb_req.we && sel_result)
				done_q <= 1'b0;
			if (rsp_valid) begin // wins over the read clear
				result_q  <= rsp.result;
				done_q    <= 1'b1;
				ovf_q     <= rsp.ovf;
				illegal_q <= rsp.illegal;
			end
		end
	end

	always_comb begin
		status = '0;
		status[st_done]    = done_q;
		status[st_ovf]     = ovf_q;
		status[st_illegal] = illegal_q;
		status[st_busy]    = busy;
	end

	always_comb begin
		rd_mux = '0; // undefined addresses read as zero
		if (sel_opa)    rd_mux = opa_q;
		if (sel_opb)    rd_mux = opb_q;
		if (sel_cmd)    rd_mux = {{(wb_dw-4){1'b0}}, cmd_q};
		if (sel_result) rd_mux = result_q;
		if (sel_status) rd_mux = status;
	end

	always_ff @(posedge clock or negedge rst_n) begin
		if (!rst_n)
			rd_q <= '0;
		else if (start && !wb_req.we)
			rd_q <= rd_mux;
	end

	assign wb_rsp.ack = (state == st_ack);
	assign wb_rsp.dat = rd_q;

endmodule

// File: design/exec_pipe.sv
/* two-stage execute pipeline, decode then alu or shifter with a registered result */
module exec_pipe (
	input  logic               clock,
	input  logic               rst_n,
	input  logic               issue_valid,
	input  alu_pkg::exec_req_t req,
	output logic               busy,
	output logic               rsp_valid,
	output alu_pkg::exec_rsp_t rsp
);
	import alu_pkg::*;

	logic              dec_shift;
	logic              dec_illegal;
	shift_func_e       dec_shf;

	logic              s1_valid;
	exec_req_t         s1_req;
	logic              s1_shift;
	logic              s1_illegal;
	shift_func_e       s1_shf;

	logic [data_w-1:0] alu_y;
	logic              alu_ovf;
	logic [data_w-1:0] shf_c;

	always_comb begin
		dec_shift   = 1'b0;
		dec_illegal = 1'b0;
		dec_shf     = shf_sll;
		case (req.op)
			op_add, op_sub, op_and, op_or, op_xor, op_nor,
			op_slt, op_sltu, op_lui: begin
				dec_shift = 1'b0;
			end
			op_sll: dec_shift = 1'b1;
			op_srl: begin
				dec_shift = 1'b1;
				dec_shf   = shf_srl;
			end
			op_sra: begin
				dec_shift = 1'b1;
				dec_shf   = shf_sra;
			end
			default: dec_illegal = 1'b1;
		endcase
	end

	always_ff @(posedge clock or negedge rst_n) begin
		if (!rst_n) begin
			s1_valid  <= 1'b0;
			rsp_valid <= 1'b0;
		end else begin
			s1_valid  <= issue_valid;
			rsp_valid <= s1_valid;
		end
	end

	always_ff @(posedge clock) begin
		if (issue_valid) begin
			s1_req     <= req;
			s1_shift   <= dec_shift;
			s1_illegal <= dec_illegal;
			s1_shf     <= dec_shf;
		end
		if (s1_valid) begin
			rsp.result  <= s1_illegal ? '0 : (s1_shift ? shf_c : alu_y);
			rsp.ovf     <= alu_ovf; // zero for every op but add and sub
			rsp.illegal <= s1_illegal;
		end
	end

	alu i_alu (
		.op  (s1_req.op),
		.a   (s1_req.a),
		.b   (s1_req.b),
		.y   (alu_y),
		.ovf (alu_ovf)
	);

	shifter i_shifter (
		.a            (s1_req.a),
		.shift_func   (s1_shf),
		.shift_amount (s1_req.b[shamt_w-1:0]), // upper b bits ignored
		.c            (shf_c)
	);

	assign busy = s1_valid | rsp_valid;

endmodule

// File: design/alu.sv
/* combinational alu with add/sub overflow flag */
module alu (
	input  alu_pkg::op_e               op,
	input  logic [alu_pkg::data_w-1:0] a,
	input  logic [alu_pkg::data_w-1:0] b,
	output logic [alu_pkg::data_w-1:0] y,
	output logic                       ovf
);
	import alu_pkg::*;

	localparam int msb = data_w - 1;

	logic [data_w-1:0] sum;
	logic [data_w-1:0] diff;
	logic              lt_signed;
	logic              lt_unsigned;

	assign sum  = a + b;
	assign diff = a - b;

	// differing signs decide directly, else the difference cannot overflow
	assign lt_signed   = (a[msb] != b[msb]) ? a[msb] : diff[msb];
	assign lt_unsigned = (a < b);

	always_comb begin
		y   = '0;
		ovf = 1'b0;
		case (op)
			op_add: begin
				y   = sum;
				ovf = (a[msb] == b[msb]) && (sum[msb] != a[msb]);
			end
			op_sub: begin
				y   = diff;
				ovf = (a[msb] != b[msb]) && (diff[msb] != a[msb]);
			end
			op_and:  y = a & b;
			op_or:   y = a | b;
			op_xor:  y = a ^ b;
			op_nor:  y = ~(a | b);
			op_slt:  y = {{(data_w-1){1'b0}}, lt_signed};
			op_sltu: y = {{(data_w-1){1'b0}}, lt_unsigned};
			op_lui:  y = {b[15:0], 16'h0000};
			default: y = '0; // shifts go through the shifter
		endcase
	end

endmodule

// File: design/shifter.sv
/* combinational 32-bit barrel shifter, left, logical right and arithmetic right */
module shifter (
	input  logic [alu_pkg::data_w-1:0]  a,
	input  alu_pkg::shift_func_e        shift_func,
	input  logic [alu_pkg::shamt_w-1:0] shift_amount,
	output logic [alu_pkg::data_w-1:0]  c
);
	import alu_pkg::*;

	logic              fill;
	logic [data_w-1:0] stage [0:shamt_w];

	// one mux level per amount bit, level i shifts by 2**i
	always_comb begin
		fill     = (shift_func == shf_sra) ? a[data_w-1] : 1'b0;
		stage[0] = a;
		for (int i = 0; i < shamt_w; i++) begin
			if (!shift_amount[i]) begin
				stage[i+1] = stage[i];
			end else if (!shift_func[1]) begin
				stage[i+1] = stage[i] << (1 << i); // zero fill from the right
			end else begin
				stage[i+1] = (stage[i] >> (1 << i)) |
					({data_w{fill}} << (data_w - (1 << i)));
			end
		end
		c = stage[shamt_w];
	end

endmodule

// File: design/bus_pkg.sv
/* wishbone classic request and response structs, register map and status bits */
package bus_pkg;

	localparam int wb_dw = 32;
	localparam int wb_aw = 5; // byte address

	typedef struct packed {
		logic             cyc;
		logic             stb;
		logic             we;
		logic [wb_aw-1:0] adr;
		logic [wb_dw-1:0] dat;
	} wb_req_t;

	typedef struct packed {
		logic             ack;
		logic [wb_dw-1:0] dat;
	} wb_rsp_t;

	localparam logic [wb_aw-1:0] adr_opa    = 5'h00;
	localparam logic [wb_aw-1:0] adr_opb    = 5'h04;
	localparam logic [wb_aw-1:0] adr_cmd    = 5'h08; // op in bits 3:0
	localparam logic [wb_aw-1:0] adr_result = 5'h0c;
	localparam logic [wb_aw-1:0] adr_status = 5'h10;

	localparam int st_done    = 0;
	localparam int st_ovf     = 1;
	localparam int st_illegal = 2;
	localparam int st_busy    = 3;

endpackage

// File: design/alu_pkg.sv
/* execute unit opcodes, shift functions and the request and response
   structs passed between the bus slave and the pipeline */
package alu_pkg;

	localparam int data_w  = 32;
	localparam int shamt_w = 5; // mips shamt field

	typedef enum logic [3:0] {
		op_add  = 4'h0,
		op_sub  = 4'h1,
		op_and  = 4'h2,
		op_or   = 4'h3,
		op_xor  = 4'h4,
		op_nor  = 4'h5,
		op_slt  = 4'h6,
		op_sltu = 4'h7,
		op_lui  = 4'h8,
		op_sll  = 4'h9,
		op_srl  = 4'ha,
		op_sra  = 4'hb
	} op_e; // 4'hc..4'hf illegal

	// bit 1 clear selects left, bit 0 picks the right fill
	typedef enum logic [1:0] {
		shf_sll = 2'b00,
		shf_srl = 2'b10,
		shf_sra = 2'b11
	} shift_func_e;

	typedef struct packed {
		op_e               op;
		logic [data_w-1:0] a;
		logic [data_w-1:0] b;
	} exec_req_t;

	typedef struct packed {
		logic [data_w-1:0] result;
		logic              ovf;
		logic              illegal;
	} exec_rsp_t;

endpackage
